//--- design/mini_cpu_defs.svh
`ifndef MINI_CPU_DEFS_SVH
`define MINI_CPU_DEFS_SVH

`define MC_DATA_W      32
`define MC_ADDR_W      12
`define MC_NREGS       16
`define MC_REG_W       4

`define MC_OP_NOP      4'd0
`define MC_OP_LD       4'd1
`define MC_OP_STR      4'd2
`define MC_OP_BRA      4'd3
`define MC_OP_XOR      4'd4
`define MC_OP_ADD      4'd5
`define MC_OP_ROT      4'd6
`define MC_OP_SHF      4'd7
`define MC_OP_HLT      4'd8
`define MC_OP_CMP      4'd9

// branch conditions, unlisted codes branch always
`define MC_CC_ALWAYS   4'd0
`define MC_CC_PARITY   4'd1
`define MC_CC_EVEN     4'd2
`define MC_CC_CARRY    4'd3
`define MC_CC_NEG      4'd4
`define MC_CC_ZERO     4'd5
`define MC_CC_NOCARRY  4'd6
`define MC_CC_POS      4'd7

`define MC_ST_FETCH    3'd0
`define MC_ST_DECODE   3'd1
`define MC_ST_EXEC     3'd2
`define MC_ST_MEM      3'd3
`define MC_ST_WB       3'd4

`endif

//--- design/mini_cpu_pkg.sv
`include "mini_cpu_defs.svh"

package mini_cpu_pkg;

    // alu and memory layout
    typedef struct packed
    {
        logic [3:0]                opcode;
        logic                      imm_sel; // 1 = use imm as second operand
        logic [`MC_REG_W-1:0]      rd;      // destination, also first operand
        logic [`MC_REG_W-1:0]      rs;
        logic [6:0]                spare;
        logic [`MC_ADDR_W-1:0]     imm;     // immediate or memory address
    } alu_fmt_t;

    // branch layout
    typedef struct packed
    {
        logic [3:0]                opcode;
        logic [3:0]                cond;
        logic [11:0]               spare;
        logic [`MC_ADDR_W-1:0]     target;
    } bra_fmt_t;

    // one instruction word, two ways to read it
    typedef union packed
    {
        alu_fmt_t                  alu;
        bra_fmt_t                  bra;
    } instr_t;

endpackage

//--- design/instr_fetch.sv
`include "mini_cpu_defs.svh"

module instr_fetch
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`MC_DATA_W-1:0]  data_in,
    input  logic [4:0]             flags,
    output logic [2:0]             step,
    output mini_cpu_pkg::instr_t   instr,
    output logic [`MC_ADDR_W-1:0]  pc,
    output logic                   halted
);

    logic started; // low for one cycle after reset
    logic cond_met;
    logic f_zero;
    logic f_neg;
    logic f_even;
    logic f_parity;
    logic f_carry;

    assign {f_zero, f_neg, f_even, f_parity, f_carry} = flags;

    // flags here come from earlier instructions, BRA leaves them alone
    always_comb
    begin
        case (instr.bra.cond)
            `MC_CC_ALWAYS:  cond_met = 1'b1;
            `MC_CC_PARITY:  cond_met = f_parity;
            `MC_CC_EVEN:    cond_met = f_even;
            `MC_CC_CARRY:   cond_met = f_carry;
            `MC_CC_NEG:     cond_met = f_neg;
            `MC_CC_ZERO:    cond_met = f_zero;
            `MC_CC_NOCARRY: cond_met = ~f_carry;
            `MC_CC_POS:     cond_met = ~f_neg & ~f_zero; // strictly positive
            default:        cond_met = 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            step    <= `MC_ST_FETCH;
            pc      <= '0;
            instr   <= '0;
            halted  <= 1'b0;
            started <= 1'b0;
        end
        else
        begin
            started <= 1'b1;
            if (started && !halted)
            begin
                case (step)
                    `MC_ST_FETCH:
                    begin
                        instr <= data_in;
                        step  <= `MC_ST_DECODE;
                    end
                    `MC_ST_EXEC:
                    begin
                        if (instr.bra.opcode == `MC_OP_HLT)
                            halted <= 1'b1; // step stays frozen here
                        else
                            step <= `MC_ST_MEM;
                    end
                    `MC_ST_WB:
                    begin
                        if (instr.bra.opcode == `MC_OP_BRA && cond_met)
                            pc <= instr.bra.target;
                        else
                            pc <= pc + 1'b1;
                        step <= `MC_ST_FETCH;
                    end
                    default:
                    begin
                        step <= step + 1'b1;
                    end
                endcase
            end
        end
    end

    step_in_range: assert property (@(posedge clk) disable iff (reset)
        step <= `MC_ST_WB)
        else $error("step counter out of range: %0d", step);

endmodule

//--- design/reg_file.sv
`include "mini_cpu_defs.svh"

module reg_file
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`MC_REG_W-1:0]   rd_a,
    input  logic [`MC_REG_W-1:0]   rd_b,
    output logic [`MC_DATA_W-1:0]  op_a,
    output logic [`MC_DATA_W-1:0]  op_b,
    input  logic                   wr_en,
    input  logic [`MC_REG_W-1:0]   wr_addr,
    input  logic [`MC_DATA_W-1:0]  wr_data
);

    logic [`MC_DATA_W-1:0] regs [`MC_NREGS];

    assign op_a = regs[rd_a];
    assign op_b = regs[rd_b];

    // every register starts at zero after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `MC_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

//--- design/exec_unit.sv
`include "mini_cpu_defs.svh"

module exec_unit
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [2:0]             step,
    input  mini_cpu_pkg::instr_t   instr,
    input  logic [`MC_DATA_W-1:0]  op_a,
    input  logic [`MC_DATA_W-1:0]  op_b,
    output logic [`MC_DATA_W-1:0]  alu_result,
    output logic [4:0]             flags
);

    logic [`MC_DATA_W-1:0]   opnd_b;
    logic [`MC_DATA_W-1:0]   result;
    logic [`MC_DATA_W:0]     wide;     // add and compare with carry bit
    logic [2*`MC_DATA_W-1:0] rot_pair;
    logic [4:0]              shamt;
    logic                    carry;
    logic                    alu_op;

    always_comb
    begin
        if (instr.alu.imm_sel)
            opnd_b = {{(`MC_DATA_W - `MC_ADDR_W){1'b0}}, instr.alu.imm};
        else
            opnd_b = op_b;

        shamt    = opnd_b[4:0];
        rot_pair = {op_a, op_a} << shamt; // upper half is the rotate
        wide     = '0;
        result   = '0;
        carry    = 1'b0;

        case (instr.alu.opcode)
            `MC_OP_ADD:
            begin
                wide   = {1'b0, op_a} + {1'b0, opnd_b};
                result = wide[`MC_DATA_W-1:0];
                carry  = wide[`MC_DATA_W];
            end
            `MC_OP_XOR: result = op_a ^ opnd_b;
            `MC_OP_ROT: result = rot_pair[2*`MC_DATA_W-1:`MC_DATA_W];
            `MC_OP_SHF: result = op_a << shamt;
            `MC_OP_CMP:
            begin
                wide   = {1'b0, op_a} - {1'b0, opnd_b};
                result = wide[`MC_DATA_W-1:0];
                carry  = ~wide[`MC_DATA_W]; // set when no borrow
            end
            default:    result = '0;
        endcase

        alu_op = (instr.alu.opcode == `MC_OP_ADD) || (instr.alu.opcode == `MC_OP_XOR) ||
                 (instr.alu.opcode == `MC_OP_ROT) || (instr.alu.opcode == `MC_OP_SHF) ||
                 (instr.alu.opcode == `MC_OP_CMP);
    end

    always_ff @(posedge clk)
    begin
        if (step == `MC_ST_EXEC)
            alu_result <= result;
    end

    // zero, neg, even, parity, carry
    always_ff @(posedge clk)
    begin
        if (reset)
            flags <= '0;
        else if (step == `MC_ST_EXEC && alu_op)
            flags <= {result == '0, result[`MC_DATA_W-1], ~result[0], ^result, carry};
    end

endmodule

//--- design/mem_writeback.sv
`include "mini_cpu_defs.svh"

module mem_writeback
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [2:0]             step,
    input  mini_cpu_pkg::instr_t   instr,
    input  logic [`MC_ADDR_W-1:0]  pc,
    input  logic [`MC_DATA_W-1:0]  op_a,
    input  logic [`MC_DATA_W-1:0]  alu_result,
    input  logic [`MC_DATA_W-1:0]  data_in,
    output logic [`MC_ADDR_W-1:0]  address,
    output logic [`MC_DATA_W-1:0]  data_out,
    output logic                   read_write,
    output logic                   mem_en,
    output logic                   wr_en,
    output logic [`MC_REG_W-1:0]   wr_addr,
    output logic [`MC_DATA_W-1:0]  wr_data
);

    logic                  started; // port stays quiet the cycle after reset
    logic [`MC_DATA_W-1:0] load_data;
    logic                  is_ld;
    logic                  is_str;
    logic                  writes_reg;

    assign is_ld      = (instr.alu.opcode == `MC_OP_LD);
    assign is_str     = (instr.alu.opcode == `MC_OP_STR);
    assign writes_reg = is_ld || (instr.alu.opcode == `MC_OP_XOR) ||
                        (instr.alu.opcode == `MC_OP_ADD) ||
                        (instr.alu.opcode == `MC_OP_ROT) ||
                        (instr.alu.opcode == `MC_OP_SHF);

    always_comb
    begin
        address    = pc;
        data_out   = op_a; // register rd for STR
        read_write = 1'b0;
        mem_en     = 1'b0;
        if (started && step == `MC_ST_FETCH)
        begin
            mem_en = 1'b1;
        end
        else if (step == `MC_ST_MEM && (is_ld || is_str))
        begin
            address    = instr.alu.imm;
            read_write = is_str;
            mem_en     = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            started <= 1'b0;
        else
            started <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (step == `MC_ST_MEM && is_ld)
            load_data <= data_in;
    end

    assign wr_en   = (step == `MC_ST_WB) && writes_reg;
    assign wr_addr = instr.alu.rd;
    assign wr_data = is_ld ? load_data : alu_result;

    write_needs_enable: assert property (@(posedge clk) disable iff (reset)
        read_write |-> mem_en)
        else $error("read_write high without mem_en");

    write_only_in_memory: assert property (@(posedge clk) disable iff (reset)
        (mem_en && read_write) |-> (step == `MC_ST_MEM))
        else $error("memory write outside MEMORY step");

endmodule

//--- design/cpu_top.sv
`include "mini_cpu_defs.svh"

module cpu_top
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`MC_DATA_W-1:0]  data_in,
    output logic [`MC_DATA_W-1:0]  data_out,
    output logic [`MC_ADDR_W-1:0]  address,
    output logic                   read_write,
    output logic                   mem_en,
    output logic                   halted
);

    import mini_cpu_pkg::*;

    logic [2:0]            step;
    instr_t                instr;
    logic [`MC_ADDR_W-1:0] pc;
    logic [4:0]            flags;
    logic [`MC_DATA_W-1:0] alu_result;
    logic [`MC_DATA_W-1:0] op_a;
    logic [`MC_DATA_W-1:0] op_b;
    logic                  wr_en;
    logic [`MC_REG_W-1:0]  wr_addr;
    logic [`MC_DATA_W-1:0] wr_data;

    instr_fetch u_fetch
    (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .flags      (flags),
        .step       (step),
        .instr      (instr),
        .pc         (pc),
        .halted     (halted)
    );

    // rd is the first operand and the store source
    reg_file u_regs
    (
        .clk        (clk),
        .reset      (reset),
        .rd_a       (instr.alu.rd),
        .rd_b       (instr.alu.rs),
        .op_a       (op_a),
        .op_b       (op_b),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    exec_unit u_exec
    (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .instr      (instr),
        .op_a       (op_a),
        .op_b       (op_b),
        .alu_result (alu_result),
        .flags      (flags)
    );

    mem_writeback u_memwb
    (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .instr      (instr),
        .pc         (pc),
        .op_a       (op_a),
        .alu_result (alu_result),
        .data_in    (data_in),
        .address    (address),
        .data_out   (data_out),
        .read_write (read_write),
        .mem_en     (mem_en),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

endmodule

//--- tb/cpu_tb.sv
`include "mini_cpu_defs.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS      = 12;
    localparam int RUN_CYCLES = 16 * 5; // 16 instructions of 5 steps

    logic        clk;
    logic        reset;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic [11:0] address;
    logic        read_write;
    logic        mem_en;
    logic        halted;

    logic [31:0] mem [4096];
    logic [31:0] prog [NROWS][16];
    logic [31:0] data [NROWS][4];     // preloaded at 0x100..0x103
    logic [11:0] exp_addr [NROWS][4];
    logic [31:0] exp_val [NROWS][4];
    int          exp_n [NROWS];
    logic [31:0] lfsr;
    logic [11:0] st_addr [$];
    logic [31:0] st_data [$];
    logic        seen_fetch;
    logic [11:0] first_addr;
    int          late_access;

    cpu_top dut
    (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .data_out   (data_out),
        .address    (address),
        .read_write (read_write),
        .mem_en     (mem_en),
        .halted     (halted)
    );

    assign data_in = mem[address]; // combinational read

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory write and port monitor
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (mem_en && read_write)
            begin
                mem[address] <= data_out;
                st_addr.push_back(address);
                st_data.push_back(data_out);
            end
            if (mem_en && !seen_fetch)
            begin
                first_addr = address;
                seen_fetch = 1'b1;
            end
            if (halted && mem_en)
                late_access++;
        end
    end

    initial
    begin
        #(2 * NROWS * RUN_CYCLES * 100);
        $display("watchdog expired, the core hung or never finished the tests");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic fail_with(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] next_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] enc_alu(input logic [3:0] op, input logic isel,
                                            input logic [3:0] rd, input logic [3:0] rs,
                                            input logic [11:0] imm);
        return {op, isel, rd, rs, 7'd0, imm};
    endfunction

    function automatic logic [31:0] enc_bra(input logic [3:0] cond, input logic [11:0] target);
        return {`MC_OP_BRA, cond, 12'd0, target};
    endfunction

    // {carry, result}
    function automatic logic [32:0] alu_calc(input logic [3:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (op)
            `MC_OP_ADD: return {1'b0, a} + {1'b0, b};
            `MC_OP_CMP: return {a >= b, a - b}; // carry is no borrow
            `MC_OP_XOR: return {1'b0, a ^ b};
            `MC_OP_ROT: return {1'b0, (s == 5'd0) ? a : ((a << s) | (a >> (6'd32 - s)))};
            `MC_OP_SHF: return {1'b0, a << s};
            default:    return '0;
        endcase
    endfunction

    function automatic logic [4:0] flags_of(input logic [32:0] r);
        return {r[31:0] == 32'd0, r[31], r[0] == 1'b0,
                ($countones(r[31:0]) % 2) == 1, r[32]};
    endfunction

    function automatic logic cond_true(input logic [3:0] c, input logic [4:0] f);
        case (c)
            `MC_CC_PARITY:  return f[1];
            `MC_CC_EVEN:    return f[2];
            `MC_CC_CARRY:   return f[0];
            `MC_CC_NEG:     return f[3];
            `MC_CC_ZERO:    return f[4];
            `MC_CC_NOCARRY: return ~f[0];
            `MC_CC_POS:     return ~f[3] & ~f[4];
            default:        return 1'b1;
        endcase
    endfunction

    task automatic build_table();
        logic [31:0] cmp_a [8] = '{32'd1, 32'd1, 32'd2, 32'd5, 32'd0, 32'd7, 32'd0, 32'd5};
        logic [31:0] cmp_b [8] = '{32'd0, 32'd0, 32'd0, 32'd3, 32'd1, 32'd7, 32'd1, 32'd3};
        logic [31:0] add_a [8] = '{32'd1, 32'd3, 32'd1, 32'd1, 32'd1, 32'd1, 32'hFFFF_FFFF, 32'd0};
        logic [31:0] add_b [8] = '{32'd1, 32'd0, 32'd0, 32'd1, 32'd0, 32'd0, 32'd2, 32'd0};
        logic [32:0] r;
        logic        tk;
        for (int i = 0; i < NROWS; i++)
        begin
            for (int k = 0; k < 16; k++)
                prog[i][k] = '0;
            for (int k = 0; k < 4; k++)
                data[i][k] = next_word();
        end
        // rows 0..7 branch once on cmp flags and once on add flags
        for (int c = 0; c < 8; c++)
        begin
            data[c] = '{cmp_a[c], cmp_b[c], add_a[c], add_b[c]};
            prog[c] = '{enc_alu(`MC_OP_LD, 1'b0, 4'd1, 4'd0, 12'h100),
                        enc_alu(`MC_OP_LD, 1'b0, 4'd2, 4'd0, 12'h101),
                        enc_alu(`MC_OP_CMP, 1'b0, 4'd1, 4'd2, 12'h000),
                        enc_bra(c[3:0], 12'd6),
                        enc_alu(`MC_OP_STR, 1'b0, 4'd1, 4'd0, 12'h200), // not taken marker
                        enc_bra(`MC_CC_ALWAYS, 12'd7),
                        enc_alu(`MC_OP_STR, 1'b0, 4'd1, 4'd0, 12'h201), // taken marker
                        enc_alu(`MC_OP_LD, 1'b0, 4'd1, 4'd0, 12'h102),
                        enc_alu(`MC_OP_LD, 1'b0, 4'd2, 4'd0, 12'h103),
                        enc_alu(`MC_OP_ADD, 1'b0, 4'd1, 4'd2, 12'h000),
                        enc_bra(c[3:0], 12'd13),
                        enc_alu(`MC_OP_STR, 1'b0, 4'd1, 4'd0, 12'h202),
                        enc_bra(`MC_CC_ALWAYS, 12'd14),
                        enc_alu(`MC_OP_STR, 1'b0, 4'd1, 4'd0, 12'h203),
                        {`MC_OP_HLT, 28'd0}, 32'd0};
            tk = cond_true(c[3:0], flags_of(alu_calc(`MC_OP_CMP, cmp_a[c], cmp_b[c])));
            exp_addr[c][0] = tk ? 12'h201 : 12'h200;
            exp_val[c][0]  = cmp_a[c];
            r  = alu_calc(`MC_OP_ADD, add_a[c], add_b[c]);
            tk = cond_true(c[3:0], flags_of(r));
            exp_addr[c][1] = tk ? 12'h203 : 12'h202;
            exp_val[c][1]  = r[31:0];
            exp_n[c] = 2;
        end
        // row 8 load and store of random words
        prog[8][0] = enc_alu(`MC_OP_LD, 1'b0, 4'd1, 4'd0, 12'h100);
        prog[8][1] = enc_alu(`MC_OP_LD, 1'b0, 4'd2, 4'd0, 12'h101);
        prog[8][2] = enc_alu(`MC_OP_STR, 1'b0, 4'd1, 4'd0, 12'h300);
        prog[8][3] = enc_alu(`MC_OP_STR, 1'b0, 4'd2, 4'd0, 12'h301);
        prog[8][4] = {`MC_OP_HLT, 28'd0};
        exp_addr[8] = '{12'h300, 12'h301, 12'h0, 12'h0};
        exp_val[8]  = '{data[8][0], data[8][1], 32'd0, 32'd0};
        exp_n[8]    = 2;
        // row 9 add, xor, rot and shf on random words
        prog[9][0]  = enc_alu(`MC_OP_LD, 1'b0, 4'd1, 4'd0, 12'h100);
        prog[9][1]  = enc_alu(`MC_OP_LD, 1'b0, 4'd2, 4'd0, 12'h101);
        prog[9][2]  = enc_alu(`MC_OP_ADD, 1'b0, 4'd1, 4'd2, 12'h000);
        prog[9][3]  = enc_alu(`MC_OP_STR, 1'b0, 4'd1, 4'd0, 12'h300);
        prog[9][4]  = enc_alu(`MC_OP_XOR, 1'b1, 4'd2, 4'd0, 12'hA5C);
        prog[9][5]  = enc_alu(`MC_OP_STR, 1'b0, 4'd2, 4'd0, 12'h301);
        prog[9][6]  = enc_alu(`MC_OP_LD, 1'b0, 4'd3, 4'd0, 12'h102);
        prog[9][7]  = enc_alu(`MC_OP_ROT, 1'b0, 4'd3, 4'd2, 12'h000);
        prog[9][8]  = enc_alu(`MC_OP_STR, 1'b0, 4'd3, 4'd0, 12'h302);
        prog[9][9]  = enc_alu(`MC_OP_LD, 1'b0, 4'd4, 4'd0, 12'h103);
        prog[9][10] = enc_alu(`MC_OP_SHF, 1'b1, 4'd4, 4'd0, 12'h007);
        prog[9][11] = enc_alu(`MC_OP_STR, 1'b0, 4'd4, 4'd0, 12'h303);
        prog[9][12] = {`MC_OP_HLT, 28'd0};
        exp_addr[9] = '{12'h300, 12'h301, 12'h302, 12'h303};
        exp_val[9][0] = data[9][0] + data[9][1];
        exp_val[9][1] = data[9][1] ^ 32'h0000_0A5C;
        r = alu_calc(`MC_OP_ROT, data[9][2], exp_val[9][1]);
        exp_val[9][2] = r[31:0];
        exp_val[9][3] = data[9][3] << 7;
        exp_n[9] = 4;
        // row 10 add wraps past 2^32
        data[10][0]  = 32'hFFFF_FFF0;
        prog[10][0]  = enc_alu(`MC_OP_LD, 1'b0, 4'd1, 4'd0, 12'h100);
        prog[10][1]  = enc_alu(`MC_OP_ADD, 1'b1, 4'd1, 4'd0, 12'h020);
        prog[10][2]  = enc_alu(`MC_OP_STR, 1'b0, 4'd1, 4'd0, 12'h300);
        prog[10][3]  = {`MC_OP_HLT, 28'd0};
        exp_addr[10] = '{12'h300, 12'h0, 12'h0, 12'h0};
        exp_val[10]  = '{32'h0000_0010, 32'd0, 32'd0, 32'd0};
        exp_n[10]    = 1;
        // row 11 relies on r1 cleared by reset
        prog[11][0]  = enc_alu(`MC_OP_ADD, 1'b1, 4'd1, 4'd0, 12'h005);
        prog[11][1]  = enc_alu(`MC_OP_STR, 1'b0, 4'd1, 4'd0, 12'h300);
        prog[11][2]  = {`MC_OP_HLT, 28'd0};
        exp_addr[11] = '{12'h300, 12'h0, 12'h0, 12'h0};
        exp_val[11]  = '{32'd5, 32'd0, 32'd0, 32'd0};
        exp_n[11]    = 1;
    endtask

    task automatic run_row(input int r);
        int cycles;
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 4096; i++)
            mem[i] <= 32'hF000_0000 | i; // unused opcode tagged with its address
        for (int k = 0; k < 16; k++)
            mem[k] <= prog[r][k];
        for (int k = 0; k < 4; k++)
            mem[12'h100 + k] <= data[r][k];
        st_addr.delete();
        st_data.delete();
        seen_fetch  = 1'b0;
        late_access = 0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value("halted in reset", {31'd0, halted}, 32'd0);
        check_value("mem_en in reset", {31'd0, mem_en}, 32'd0);
        check_value("read_write in reset", {31'd0, read_write}, 32'd0);
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("mem_en after reset", {31'd0, mem_en}, 32'd0);
        cycles = 0;
        while (!halted && cycles < RUN_CYCLES + 5)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!halted)
            fail_with($sformatf("row %0d: halted never rose", r));
        if (!seen_fetch)
            fail_with($sformatf("row %0d: no fetch seen after reset", r));
        check_value("first fetch address", {20'd0, first_addr}, 32'd0);
        repeat (20)
        begin
            @(negedge clk);
            check_value("halted after halt", {31'd0, halted}, 32'd1);
        end
        if (late_access != 0)
            fail_with($sformatf("row %0d: memory accessed after halted rose", r));
        if (st_addr.size() != exp_n[r])
            fail_with($sformatf("row %0d: %0d stores seen, %0d expected",
                                r, st_addr.size(), exp_n[r]));
        for (int k = 0; k < exp_n[r]; k++)
        begin
            check_value($sformatf("row %0d store %0d address", r, k),
                        {20'd0, st_addr[k]}, {20'd0, exp_addr[r][k]});
            check_value($sformatf("row %0d store %0d data_out", r, k), st_data[k], exp_val[r][k]);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        lfsr  = 32'd49;
        build_table();
        for (int r = 0; r < NROWS; r++)
            run_row(r);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- mini_cpu.f
+incdir+design
design/mini_cpu_pkg.sv
design/instr_fetch.sv
design/reg_file.sv
design/exec_unit.sv
design/mem_writeback.sv
design/cpu_top.sv
tb/cpu_tb.sv

//--- Makefile
TOP       ?= cpu_tb
FILELIST  ?= mini_cpu.f
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv design/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "PASS: all tests" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
